//--- verilog/dram_user_pkg.sv
package dram_user_pkg;

    // byte address as issued by the core
    typedef logic [31:0] user_addr_t;

    // one write word
    typedef logic [31:0] user_word_t;

    // byte mask, a set bit keeps the byte untouched
    typedef logic [3:0] user_mask_t;

    // request queue entry, mask stays zero for reads
    typedef struct packed {
        logic       is_write;
        user_addr_t addr;
        user_word_t data;
        user_mask_t mask;
    } user_req_t;

    // core-side states
    typedef enum logic [1:0] {
        CALIB = 2'b00,
        IDLE  = 2'b01,
        WRITE = 2'b10,
        READ  = 2'b11
    } fe_state_e;

endpackage

//--- verilog/dram_app_pkg.sv
package dram_app_pkg;

    localparam int APP_ADDR_W     = 28;
    localparam int APP_DATA_W     = 128;
    localparam int APP_MASK_W     = 16;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [APP_DATA_W-1:0] app_line_t;

    // application port opcodes
    typedef enum logic [2:0] {
        WRITE = 3'b000,
        READ  = 3'b001
    } app_cmd_e;

    // command channel, held until en meets rdy
    typedef struct packed {
        logic                  en;
        app_cmd_e              cmd;
        logic [APP_ADDR_W-1:0] addr;
    } app_cmd_t;

    // write data channel, wren also marks the end of the burst
    typedef struct packed {
        logic                  wren;
        app_line_t             data;
        logic [APP_MASK_W-1:0] mask;
    } app_wdf_t;

    // read return from the memory side
    typedef struct packed {
        logic      valid;
        app_line_t data;
    } app_rd_t;

    typedef enum logic [2:0] {
        CALIB           = 3'b000,
        IDLE            = 3'b001,
        ISSUE_CMD_WDATA = 3'b010,
        ISSUE_CMD       = 3'b011,
        ISSUE_WDATA     = 3'b100
    } iss_state_e;

endpackage

//--- verilog/dram_sync_fifo.sv
`timescale 1ns/100ps

module dram_sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_x_async,
    input  logic             i_push,
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // push on full is dropped, pop on empty ignored
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head visible without a read cycle
    assign o_data  = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));

endmodule

//--- verilog/dram_req_frontend.sv
`timescale 1ns/100ps

module dram_req_frontend (
    input  logic                       clk,
    input  logic                       rst_x_async,
    input  logic                       i_init_calib_complete,
    input  logic                       i_wr_en,
    input  logic                       i_rd_en,
    input  dram_user_pkg::user_addr_t  i_addr,
    input  dram_user_pkg::user_word_t  i_data,
    input  dram_user_pkg::user_mask_t  i_mask,
    output logic                       o_req_push,
    output dram_user_pkg::user_req_t   o_req,
    input  logic                       i_req_full,
    input  logic                       i_ret_empty,
    output logic                       o_ret_pop,
    input  dram_app_pkg::app_line_t    i_ret_line,
    output logic                       o_busy,
    output logic                       o_init_calib_complete,
    output dram_app_pkg::app_line_t    o_data
);

    logic                     calib_sync1;
    logic                     calib_sync2;
    dram_user_pkg::fe_state_e state;

    // calibration flag through two flops
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_init_calib_complete;
            calib_sync2 <= calib_sync1;
        end
    end

    assign o_init_calib_complete = calib_sync2;

    // the request enters the queue on the accepting edge, write wins over read
    assign o_req_push = (state == dram_user_pkg::IDLE) && (i_wr_en || i_rd_en);
    assign o_req = '{
        is_write: i_wr_en,
        addr:     i_addr,
        data:     i_data,
        mask:     i_wr_en ? i_mask : '0
    };

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= dram_user_pkg::CALIB;
        end else begin
            case (state)
                dram_user_pkg::CALIB: begin
                    if (calib_sync2) begin
                        state <= dram_user_pkg::IDLE;
                    end
                end
                dram_user_pkg::IDLE: begin
                    if (i_wr_en) begin
                        state <= dram_user_pkg::WRITE;
                    end else if (i_rd_en) begin
                        state <= dram_user_pkg::READ;
                    end
                end
                dram_user_pkg::WRITE: begin
                    // hold the core off while the queue has no room
                    if (!i_req_full) begin
                        state <= dram_user_pkg::IDLE;
                    end
                end
                dram_user_pkg::READ: begin
                    // line is back, released on the same edge it is popped
                    if (!i_ret_empty) begin
                        state <= dram_user_pkg::IDLE;
                    end
                end
                default: begin
                    state <= dram_user_pkg::CALIB;
                end
            endcase
        end
    end

    // drain the return queue as soon as a line shows up
    assign o_ret_pop = !i_ret_empty;

    always_ff @(posedge clk) begin
        if (o_ret_pop) begin
            o_data <= i_ret_line;
        end
    end

    assign o_busy = (state != dram_user_pkg::IDLE);

endmodule

//--- verilog/dram_app_issuer.sv
`timescale 1ns/100ps

module dram_app_issuer (
    input  logic                      clk,
    input  logic                      rst_x_async,
    input  logic                      i_init_calib_complete,
    input  logic                      i_req_empty,
    input  dram_user_pkg::user_req_t  i_req,
    output logic                      o_req_pop,
    output dram_app_pkg::app_cmd_t    o_app,
    output dram_app_pkg::app_wdf_t    o_app_wdf,
    input  logic                      i_app_rdy,
    input  logic                      i_app_wdf_rdy
);

    dram_app_pkg::iss_state_e                state;
    logic                                    slot_free;
    logic [dram_app_pkg::APP_ADDR_W-1:0]     pk_addr;
    dram_app_pkg::app_line_t                 pk_data;
    logic [dram_app_pkg::APP_MASK_W-1:0]     lane_wr;
    logic [dram_app_pkg::APP_MASK_W-1:0]     pk_mask;

    // line address, byte address 26:4 with the low three bits cleared
    assign pk_addr = {
        {(dram_app_pkg::APP_ADDR_W - 26){1'b0}},
        i_req.addr[26:4],
        3'b000
    };

    // same word in every lane, the mask picks the one that lands
    assign pk_data = {dram_app_pkg::WORDS_PER_LINE{i_req.data}};

    // bytes to write, moved to the lane from addr 3:2
    assign lane_wr = {{(dram_app_pkg::APP_MASK_W - 4){1'b0}}, ~i_req.mask}
                     << {i_req.addr[3:2], 2'b00};
    assign pk_mask = ~lane_wr;

    // nothing pending after this edge
    always_comb begin
        case (state)
            dram_app_pkg::CALIB:           slot_free = 1'b0;
            dram_app_pkg::IDLE:            slot_free = 1'b1;
            dram_app_pkg::ISSUE_CMD_WDATA: slot_free = i_app_rdy && i_app_wdf_rdy;
            dram_app_pkg::ISSUE_CMD:       slot_free = i_app_rdy;
            dram_app_pkg::ISSUE_WDATA:     slot_free = i_app_wdf_rdy;
            default:                       slot_free = 1'b1;
        endcase
    end

    assign o_req_pop = slot_free && !i_req_empty;

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state     <= dram_app_pkg::CALIB;
            o_app     <= '0;
            o_app_wdf <= '0;
        end else begin
            case (state)
                dram_app_pkg::CALIB: begin
                    if (i_init_calib_complete) begin
                        state <= dram_app_pkg::IDLE;
                    end
                end
                dram_app_pkg::ISSUE_CMD_WDATA: begin
                    // one side taken, keep waiting on the other
                    if (!slot_free) begin
                        if (i_app_rdy) begin
                            o_app.en <= 1'b0;
                            state    <= dram_app_pkg::ISSUE_WDATA;
                        end else if (i_app_wdf_rdy) begin
                            o_app_wdf.wren <= 1'b0;
                            state          <= dram_app_pkg::ISSUE_CMD;
                        end
                    end
                end
                default: begin
                end
            endcase

            if (slot_free) begin
                if (!i_req_empty) begin
                    o_app.en   <= 1'b1;
                    o_app.addr <= pk_addr;
                    if (i_req.is_write) begin
                        o_app.cmd <= dram_app_pkg::WRITE;
                        o_app_wdf <= '{wren: 1'b1, data: pk_data, mask: pk_mask};
                        state     <= dram_app_pkg::ISSUE_CMD_WDATA;
                    end else begin
                        // read keeps the old write data, only wren drops
                        o_app.cmd      <= dram_app_pkg::READ;
                        o_app_wdf.wren <= 1'b0;
                        state          <= dram_app_pkg::ISSUE_CMD;
                    end
                end else begin
                    o_app.en       <= 1'b0;
                    o_app_wdf.wren <= 1'b0;
                    state          <= dram_app_pkg::IDLE;
                end
            end
        end
    end

endmodule

//--- verilog/dram_ctrl_top.sv
`timescale 1ns/100ps

module dram_ctrl_top #(
    parameter int REQ_DEPTH = 4,
    parameter int RET_DEPTH = 2
) (
    input  logic                       clk,
    input  logic                       rst_x_async,
    input  logic                       i_init_calib_complete,
    input  logic                       i_wr_en,
    input  logic                       i_rd_en,
    input  dram_user_pkg::user_addr_t  i_addr,
    input  dram_user_pkg::user_word_t  i_data,
    input  dram_user_pkg::user_mask_t  i_mask,
    output logic                       o_busy,
    output logic                       o_init_calib_complete,
    output dram_app_pkg::app_line_t    o_data,
    output dram_app_pkg::app_cmd_t     o_app,
    output dram_app_pkg::app_wdf_t     o_app_wdf,
    input  logic                       i_app_rdy,
    input  logic                       i_app_wdf_rdy,
    input  dram_app_pkg::app_rd_t      i_app_rd
);

    logic                      req_push;
    dram_user_pkg::user_req_t  req_in;
    logic                      req_full;
    logic                      req_pop;
    logic                      req_empty;
    dram_user_pkg::user_req_t  req_head;

    logic                      ret_pop;
    logic                      ret_empty;
    dram_app_pkg::app_line_t   ret_line;

    dram_req_frontend i_frontend (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_wr_en               (i_wr_en),
        .i_rd_en               (i_rd_en),
        .i_addr                (i_addr),
        .i_data                (i_data),
        .i_mask                (i_mask),
        .o_req_push            (req_push),
        .o_req                 (req_in),
        .i_req_full            (req_full),
        .i_ret_empty           (ret_empty),
        .o_ret_pop             (ret_pop),
        .i_ret_line            (ret_line),
        .o_busy                (o_busy),
        .o_init_calib_complete (o_init_calib_complete),
        .o_data                (o_data)
    );

    // core requests toward the issuer
    dram_sync_fifo #(
        .DEPTH (REQ_DEPTH),
        .WIDTH ($bits(dram_user_pkg::user_req_t))
    ) i_req_fifo (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (req_push),
        .i_data      (req_in),
        .i_pop       (req_pop),
        .o_data      (req_head),
        .o_empty     (req_empty),
        .o_full      (req_full)
    );

    dram_app_issuer i_issuer (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_req_empty           (req_empty),
        .i_req                 (req_head),
        .o_req_pop             (req_pop),
        .o_app                 (o_app),
        .o_app_wdf             (o_app_wdf),
        .i_app_rdy             (i_app_rdy),
        .i_app_wdf_rdy         (i_app_wdf_rdy)
    );

    // read lines back to the core, one per outstanding read
    dram_sync_fifo #(
        .DEPTH (RET_DEPTH),
        .WIDTH ($bits(dram_app_pkg::app_line_t))
    ) i_ret_fifo (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd.valid),
        .i_data      (i_app_rd.data),
        .i_pop       (ret_pop),
        .o_data      (ret_line),
        .o_empty     (ret_empty),
        .o_full      ()
    );

endmodule

//--- testbench/dram_ctrl_props.sv
`timescale 1ns/100ps

module dram_ctrl_props (
    input logic                   clk,
    input logic                   rst_x_async,
    input logic                   o_busy,
    input dram_app_pkg::app_cmd_t o_app,
    input dram_app_pkg::app_wdf_t o_app_wdf,
    input logic                   i_app_rdy,
    input logic                   i_app_wdf_rdy
);

    int fail_count = 0;

    // command waits unchanged until rdy takes it
    cmd_hold: assert property (@(posedge clk) disable iff (!rst_x_async)
        o_app.en && !i_app_rdy |=> $stable(o_app))
    else begin
        fail_count++;
        $error("app command changed before it was taken");
    end

    wdf_hold: assert property (@(posedge clk) disable iff (!rst_x_async)
        o_app_wdf.wren && !i_app_wdf_rdy |=> $stable(o_app_wdf))
    else begin
        fail_count++;
        $error("app write data changed before it was taken");
    end

    busy_in_reset: assert property (@(posedge clk) !rst_x_async |-> o_busy)
    else begin
        fail_count++;
        $error("busy low while in reset");
    end

endmodule

bind dram_ctrl_top dram_ctrl_props i_props (
    .clk           (clk),
    .rst_x_async   (rst_x_async),
    .o_busy        (o_busy),
    .o_app         (o_app),
    .o_app_wdf     (o_app_wdf),
    .i_app_rdy     (i_app_rdy),
    .i_app_wdf_rdy (i_app_wdf_rdy)
);

//--- testbench/tb_dram_ctrl.sv
`timescale 1ns/100ps

module tb_dram_ctrl;

    localparam int REQ_DEPTH  = 4;
    localparam int READ_LAT   = 3;
    // five tests of about 500 cycles each plus margin
    localparam int MAX_CYCLES = 4000;

    logic                      clk;
    logic                      rst_x_async;
    logic                      calib;
    logic                      wr_en;
    logic                      rd_en;
    dram_user_pkg::user_addr_t addr;
    dram_user_pkg::user_word_t wdata;
    dram_user_pkg::user_mask_t mask;
    logic                      busy;
    logic                      calib_done;
    dram_app_pkg::app_line_t   rdata;
    dram_app_pkg::app_cmd_t    app;
    dram_app_pkg::app_wdf_t    app_wdf;
    logic                      app_rdy;
    logic                      app_wdf_rdy;
    dram_app_pkg::app_rd_t     app_rd;

    // model memory and predicted contents by line address
    dram_app_pkg::app_line_t   mem [256];
    dram_app_pkg::app_line_t   exp_mem [256];
    logic [7:0]                wr_line_q [$];
    dram_app_pkg::app_wdf_t    wr_data_q [$];
    dram_app_pkg::app_line_t   rd_line;
    dram_app_pkg::app_cmd_t    first_cmd;
    logic                      first_seen;
    logic                      rand_rdy;
    logic                      rdy_level;
    integer                    seed;
    int                        rd_wait;
    int                        cmds_taken;
    int                        reqs_sent;
    int                        checks;
    int                        errors;
    int                        cycles;

    dram_ctrl_top #(
        .REQ_DEPTH (REQ_DEPTH),
        .RET_DEPTH (2)
    ) i_dut (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (calib),
        .i_wr_en               (wr_en),
        .i_rd_en               (rd_en),
        .i_addr                (addr),
        .i_data                (wdata),
        .i_mask                (mask),
        .o_busy                (busy),
        .o_init_calib_complete (calib_done),
        .o_data                (rdata),
        .o_app                 (app),
        .o_app_wdf             (app_wdf),
        .i_app_rdy             (app_rdy),
        .i_app_wdf_rdy         (app_wdf_rdy),
        .i_app_rd              (app_rd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no progress after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // memory side of the application port
    always @(posedge clk) begin : mem_model
        logic [31:0]            r;
        logic [7:0]             line;
        dram_app_pkg::app_wdf_t w;
        app_rd.valid <= 1'b0;
        if (rand_rdy) begin
            r = $random(seed);
            app_rdy     <= r[0];
            app_wdf_rdy <= r[1];
        end else begin
            app_rdy     <= rdy_level;
            app_wdf_rdy <= rdy_level;
        end
        if (app.en && app_rdy) begin
            cmds_taken++;
            if (!first_seen) begin
                first_cmd  = app;
                first_seen = 1'b1;
            end
            if (app.cmd == dram_app_pkg::WRITE) begin
                wr_line_q.push_back(app.addr[10:3]);
            end
        end
        if (app_wdf.wren && app_wdf_rdy) begin
            wr_data_q.push_back(app_wdf);
        end
        while (wr_line_q.size() > 0 && wr_data_q.size() > 0) begin
            line = wr_line_q.pop_front();
            w    = wr_data_q.pop_front();
            for (int b = 0; b < 16; b++) begin
                if (!w.mask[b]) begin
                    mem[line][b*8 +: 8] = w.data[b*8 +: 8];
                end
            end
        end
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                app_rd <= '{valid: 1'b1, data: rd_line};
            end
        end
        if (app.en && app_rdy && app.cmd == dram_app_pkg::READ) begin
            rd_line = mem[app.addr[10:3]];
            rd_wait = READ_LAT;
        end
    end

    task automatic compare_line(input string name, input dram_app_pkg::app_line_t exp,
                                input dram_app_pkg::app_line_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_cmd(input string name, input dram_app_pkg::app_cmd_t exp,
                               input dram_app_pkg::app_cmd_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // hold the enable until an edge where busy was low
    task automatic send_req(input logic is_wr, input dram_user_pkg::user_addr_t a,
                            input dram_user_pkg::user_word_t d,
                            input dram_user_pkg::user_mask_t m);
        @(posedge clk);
        wr_en <= is_wr;
        rd_en <= !is_wr;
        addr  <= a;
        wdata <= d;
        mask  <= m;
        do @(posedge clk); while (busy);
        wr_en <= 1'b0;
        rd_en <= 1'b0;
        reqs_sent++;
    endtask

    // only bytes with a clear mask bit land in lane addr 3:2
    task automatic write_word(input dram_user_pkg::user_addr_t a,
                              input dram_user_pkg::user_word_t d,
                              input dram_user_pkg::user_mask_t m);
        int lane;
        send_req(1'b1, a, d, m);
        lane = a[3:2];
        for (int b = 0; b < 4; b++) begin
            if (!m[b]) begin
                exp_mem[a[11:4]][lane*32 + b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic read_check(input string name, input dram_user_pkg::user_addr_t a);
        send_req(1'b0, a, '0, '0);
        do @(posedge clk); while (busy);
        compare_line(name, exp_mem[a[11:4]], rdata);
    endtask

    task automatic calib_gating();
        int e0;
        e0 = errors;
        // a write held up during calibration must not reach the port
        wr_en <= 1'b1;
        addr  <= 32'h0000_0f00;
        repeat (8) begin
            @(posedge clk);
            compare_bit("calib busy", 1'b1, busy);
            compare_bit("calib app en", 1'b0, app.en);
        end
        wr_en <= 1'b0;
        calib <= 1'b1;
        repeat (2) @(posedge clk);
        compare_bit("calib sync low", 1'b0, calib_done);
        @(posedge clk);
        compare_bit("calib sync high", 1'b1, calib_done);
        compare_bit("calib busy held", 1'b1, busy);
        compare_bit("calib no command", 1'b0, app.en);
        @(posedge clk);
        compare_bit("calib busy falls", 1'b0, busy);
        report_test("calibration gating", e0);
    endtask

    task automatic write_then_read();
        int                        e0;
        dram_app_pkg::app_cmd_t    exp_cmd;
        dram_user_pkg::user_addr_t base;
        e0   = errors;
        base = 32'h0000_0450;
        // 16-byte line index times eight
        exp_cmd = '{en: 1'b1, cmd: dram_app_pkg::WRITE,
                    addr: 28'((base & 32'h07ff_fff0) >> 1)};
        for (int i = 0; i < 4; i++) begin
            write_word(base + 32'(i * 4), 32'hC0DE_0000 + 32'(i * 32'h0101), 4'b0000);
        end
        for (int i = 0; i < 4; i++) begin
            read_check("write read lane", base + 32'(i * 4));
        end
        compare_cmd("write read first cmd", exp_cmd, first_cmd);
        report_test("write then read", e0);
    endtask

    task automatic partial_mask_write();
        int e0;
        e0 = errors;
        write_word(32'h0000_0a04, 32'hA5A5_A5A5, 4'b0000);
        write_word(32'h0000_0a04, 32'h1234_5678, 4'b1010);
        read_check("byte mask read", 32'h0000_0a04);
        report_test("byte mask", e0);
    endtask

    task automatic random_backpressure();
        int                        e0;
        logic [31:0]               r;
        dram_user_pkg::user_addr_t a;
        e0 = errors;
        rand_rdy <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            a = 32'h0000_0600 | {24'h0, r[5:0], 2'b00};
            if (r[8]) begin
                write_word(a, $random(seed), r[12:9]);
            end else begin
                read_check("backpressure read", a);
            end
        end
        read_check("backpressure last read", a);
        if (cmds_taken != reqs_sent) begin
            errors++;
            $display("ERROR backpressure commands expected %0d actual %0d",
                     reqs_sent, cmds_taken);
        end
        rand_rdy <= 1'b0;
        report_test("back-pressure", e0);
    endtask

    task automatic queue_fill();
        int e0;
        e0 = errors;
        rdy_level <= 1'b0;
        for (int i = 0; i <= REQ_DEPTH; i++) begin
            write_word(32'h0000_0800 + 32'(i * 20), 32'hF00D_0000 + 32'(i), 4'b0000);
        end
        repeat (10) @(posedge clk);
        compare_bit("queue fill busy", 1'b1, busy);
        rdy_level <= 1'b1;
        for (int i = 0; i <= REQ_DEPTH; i++) begin
            read_check("queue fill read", 32'h0000_0800 + 32'(i * 20));
        end
        report_test("queue fill", e0);
    endtask

    initial begin
        rst_x_async = 1'b0;
        calib       = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        wdata       = '0;
        mask        = '0;
        app_rdy     = 1'b1;
        app_wdf_rdy = 1'b1;
        app_rd      = '0;
        rand_rdy    = 1'b0;
        rdy_level   = 1'b1;
        first_seen  = 1'b0;
        seed        = 1;
        rd_wait     = 0;
        cmds_taken  = 0;
        reqs_sent   = 0;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i]     = '0;
            exp_mem[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_x_async <= 1'b1;
        calib_gating();
        write_then_read();
        partial_mask_write();
        random_backpressure();
        queue_fill();
        errors += i_dut.i_props.fail_count;
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/dram_user_pkg.sv
verilog/dram_app_pkg.sv
verilog/dram_sync_fifo.sv
verilog/dram_req_frontend.sv
verilog/dram_app_issuer.sv
verilog/dram_ctrl_top.sv
testbench/dram_ctrl_props.sv
testbench/tb_dram_ctrl.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_dram_ctrl || exit 1
out=$(./obj_dir/Vtb_dram_ctrl +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "STATUS: PASS" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
